//--- build.f
+incdir+src
src/mips_pkg.sv
src/controller.sv
src/alu.sv
src/reg_file.sv
src/datapath.sv
src/mips_cpu_harvard.sv
tests/tb_mips_cpu.sv

//--- Makefile
# Verilator build and run of the single-cycle MIPS regression

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run tb_mips_cpu"
	@echo "make clean  remove the Verilator build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing -Wno-fatal --top-module tb_mips_cpu -f build.f -Mdir obj_dir -o tb_mips_cpu
	@out=$$(./obj_dir/tb_mips_cpu); echo "$$out"; echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf obj_dir

//--- tests/tb_mips_cpu.sv
`timescale 1ns/1ps
`include "mips_cfg.svh"

module tb_mips_cpu import mips_pkg::*; ();

  localparam int ROM_WORDS    = 256;
  localparam int RAM_WORDS    = 64;
  localparam int NUM_PROGS    = 20;
  localparam int RESET_CYCLES = 16;
  localparam int CLK_PERIOD   = 100;
  localparam int MAIN_END     = 200;           // addiu $30,$0,0 then jr $30
  localparam int SUB_START    = MAIN_END + 2;  // jal target with 7 ops then jr $31
  localparam longint WATCHDOG_NS =
    longint'(NUM_PROGS) * (ROM_WORDS * 4 + RESET_CYCLES) * CLK_PERIOD;
  localparam logic [5:0] RR_FUNCTS [7] = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR,
                                           FN_XOR, FN_SLT, FN_SLTU};

  logic  clk = 1'b0;
  logic  rst_n, clk_enable;
  logic  active, data_write, data_read;
  word_t instr_readdata, data_readdata, register_v0;
  word_t instr_address, data_address, data_writedata;

  word_t rom [ROM_WORDS];          // mapped at the reset vector
  word_t ram [RAM_WORDS];          // what the DUT sees
  word_t m_regs [`MIPS_NUM_REGS];  // ISA model state
  word_t m_ram [RAM_WORDS];
  word_t m_pc, rom_off;
  logic  m_active;
  word_t rng_state = 32'd67668;
  int    prog = 0;

  mips_cpu_harvard dut_i (
    .clk(clk), .rst_n(rst_n), .active(active), .register_v0(register_v0),
    .clk_enable(clk_enable),
    .instr_address(instr_address), .instr_readdata(instr_readdata),
    .data_address(data_address), .data_write(data_write), .data_read(data_read),
    .data_writedata(data_writedata), .data_readdata(data_readdata)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // comb fetch with nop outside the ROM window
  assign rom_off        = instr_address - `MIPS_RESET_VECTOR;
  assign instr_readdata = (rom_off < word_t'(ROM_WORDS * 4)) ? rom[rom_off[9:2]] : '0;
  assign data_readdata  = ram[data_address[7:2]];

  always @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < RAM_WORDS; i++) ram[i] <= fill_word(i);  // fresh per program
    end else if (data_write) begin
      ram[data_address[7:2]] <= data_writedata;
    end
  end

  function automatic word_t xorshift32();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  // distinct per word index and per program
  function automatic word_t fill_word(int idx);
    return (word_t'(idx) * 32'h9E3779B1) ^ (word_t'(prog) << 24);
  endfunction

  function automatic instr_t enc_r(logic [4:0] rs, rt, rd, shamt, logic [5:0] fn);
    instr_t w;
    w.r = '{OP_RTYPE, rs, rt, rd, shamt, fn};
    return w;
  endfunction

  function automatic instr_t enc_i(logic [5:0] op, logic [4:0] rs, rt, logic [15:0] imm);
    instr_t w;
    w.i = '{op, rs, rt, imm};
    return w;
  endfunction

  // random non-control op with dest below $26 so $28/$30/$31 survive
  function automatic instr_t gen_alu();
    logic [4:0]  rd, rs, rt;
    logic [15:0] imm;
    rd  = 5'(xorshift32() % 26);   // $0 included so its writes must vanish
    rs  = 5'(xorshift32());
    rt  = 5'(xorshift32());
    imm = 16'(xorshift32());
    case (xorshift32() % 12)
      0:  return enc_r(5'd0, rt, rd, 5'(xorshift32()), FN_SLL);
      1:  return enc_r(5'd0, rt, rd, 5'(xorshift32()), FN_SRL);
      2:  return enc_i(OP_ADDIU, rs, rd, imm);
      3:  return enc_i(OP_SLTI, rs, rd, imm);
      4:  return enc_i(OP_ANDI, rs, rd, imm);
      5:  return enc_i(OP_ORI, rs, rd, imm);
      6:  return enc_i(OP_XORI, rs, rd, imm);
      7:  return enc_i(OP_LUI, 5'd0, rd, imm);
      8:  return enc_i(OP_LW, 5'd28, rd, {8'h00, imm[5:0], 2'b00});  // $28 base within RAM
      9:  return enc_i(OP_SW, 5'd28, rt, {8'h00, imm[5:0], 2'b00});
      default: return enc_r(rs, rt, rd, 5'd0, RR_FUNCTS[xorshift32() % 7]);
    endcase
  endfunction

  task automatic gen_program();
    int         t;
    word_t      tgt;
    logic [4:0] rs, rt;
    for (int k = 0; k < ROM_WORDS; k++) rom[k] = '0;  // sll $0,$0,0 padding
    for (int k = 1; k <= 25; k++) begin
      rom[k - 1] = enc_i((xorshift32() % 2 == 0) ? OP_ADDIU : OP_LUI,
                         5'd0, 5'(k), 16'(xorshift32()));
    end
    rom[25] = enc_i(OP_ADDIU, 5'd0, 5'd28, 16'h0100);  // load/store base
    tgt     = `MIPS_RESET_VECTOR + word_t'(SUB_START * 4);
    rom[26] = {OP_JAL, tgt[27:2]};                      // always reached
    for (int k = 27; k < MAIN_END; k++) begin
      t = k + 1 + int'(xorshift32() % 6);               // forward only
      if (t > MAIN_END) t = MAIN_END;
      rs  = 5'(xorshift32());
      rt  = (xorshift32() % 2 == 0) ? rs : 5'(xorshift32());  // bias to taken
      tgt = `MIPS_RESET_VECTOR + word_t'(t * 4);
      case (xorshift32() % 16)
        0:       rom[k] = enc_i(OP_BEQ, rs, rt, 16'(t - k - 1));
        1:       rom[k] = enc_i(OP_BNE, rs, rt, 16'(t - k - 1));
        2:       rom[k] = {OP_J, tgt[27:2]};
        default: rom[k] = gen_alu();
      endcase
    end
    rom[MAIN_END]     = enc_i(OP_ADDIU, 5'd0, 5'd30, 16'h0000);
    rom[MAIN_END + 1] = enc_r(5'd30, 5'd0, 5'd0, 5'd0, FN_JR);  // jump to halt
    for (int k = SUB_START; k < SUB_START + 7; k++) rom[k] = gen_alu();
    rom[SUB_START + 7] = enc_r(5'd31, 5'd0, 5'd0, 5'd0, FN_JR);
  endtask

  task automatic reset_model();
    for (int i = 0; i < `MIPS_NUM_REGS; i++) m_regs[i] = '0;
    for (int i = 0; i < RAM_WORDS; i++) m_ram[i] = fill_word(i);
    m_pc     = `MIPS_RESET_VECTOR;
    m_active = 1'b1;
  endtask

  task automatic stop_on_failure();
    $display("Regression failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic report_error(string msg);
    $display("[ERROR] %0t ns: %s", $time, msg);
    stop_on_failure();
  endtask

  task automatic check_pc(word_t exp);
    if (instr_address !== exp)
      report_error($sformatf("pc %08h, expected %08h", instr_address, exp));
  endtask

  task automatic check_store(word_t addr, word_t data);
    if (data_address !== addr || data_writedata !== data)
      report_error($sformatf("store %08h <- %08h, expected %08h <- %08h",
                             data_address, data_writedata, addr, data));
  endtask

  task automatic check_v0(word_t exp);
    if (register_v0 !== exp)
      report_error($sformatf("v0 %08h, expected %08h", register_v0, exp));
  endtask

  task automatic check_active(logic exp);
    if (active !== exp)
      report_error($sformatf("active %b, expected %b", active, exp));
  endtask

  task automatic check_write(logic exp);
    if (data_write !== exp)
      report_error($sformatf("data_write %b, expected %b", data_write, exp));
  endtask

  task automatic check_read(logic exp);
    if (data_read !== exp)
      report_error($sformatf("data_read %b, expected %b", data_read, exp));
  endtask

  // one retired instruction per the ISA rules
  task automatic model_step();
    instr_t     ins;
    word_t      off, rs, rt, sext, zext, pc4, res, nxt, addr;
    logic       wr, is_sw, is_lw;
    logic [4:0] dst;
    off  = m_pc - `MIPS_RESET_VECTOR;
    ins  = (off < word_t'(ROM_WORDS * 4)) ? rom[off[9:2]] : '0;
    rs   = m_regs[ins.r.rs];
    rt   = m_regs[ins.r.rt];
    sext = {{16{ins.i.imm16[15]}}, ins.i.imm16};
    zext = {16'h0000, ins.i.imm16};
    pc4  = m_pc + 32'd4;
    addr = rs + sext;
    nxt  = pc4;
    res  = '0;
    wr   = 1'b1;
    is_sw = 1'b0;
    is_lw = 1'b0;
    dst  = ins.i.rt;
    case (ins.r.op)
      OP_RTYPE: begin
        dst = ins.r.rd;
        case (ins.r.funct)
          FN_ADDU: res = rs + rt;
          FN_SUBU: res = rs - rt;
          FN_AND:  res = rs & rt;
          FN_OR:   res = rs | rt;
          FN_XOR:  res = rs ^ rt;
          FN_SLT:  res = word_t'($signed(rs) < $signed(rt));
          FN_SLTU: res = word_t'(rs < rt);
          FN_SLL:  res = rt << ins.r.shamt;
          FN_SRL:  res = rt >> ins.r.shamt;
          FN_JR: begin
            wr  = 1'b0;
            nxt = rs;
          end
          default: wr = 1'b0;
        endcase
      end
      OP_ADDIU: res = rs + sext;
      OP_SLTI:  res = word_t'($signed(rs) < $signed(sext));
      OP_ANDI:  res = rs & zext;
      OP_ORI:   res = rs | zext;
      OP_XORI:  res = rs ^ zext;
      OP_LUI:   res = {ins.i.imm16, 16'h0000};
      OP_LW: begin
        res   = m_ram[addr[7:2]];
        is_lw = 1'b1;
      end
      OP_SW: begin
        wr    = 1'b0;
        is_sw = 1'b1;
      end
      OP_BEQ: begin
        wr = 1'b0;
        if (rs == rt) nxt = pc4 + (sext << 2);
      end
      OP_BNE: begin
        wr = 1'b0;
        if (rs != rt) nxt = pc4 + (sext << 2);
      end
      OP_J: begin
        wr  = 1'b0;
        nxt = {pc4[31:28], ins.j.target26, 2'b00};
      end
      OP_JAL: begin
        dst = 5'd31;   // link to pc+4 as there is no delay slot
        res = pc4;
        nxt = {pc4[31:28], ins.j.target26, 2'b00};
      end
      default: wr = 1'b0;
    endcase
    check_write(is_sw);
    check_read(is_lw);
    if (is_sw) begin
      check_store(addr, rt);
      m_ram[addr[7:2]] = rt;
    end
    if (wr && dst != 5'd0) m_regs[dst] = res;
    m_pc     = nxt;
    m_active = (nxt != `MIPS_HALT_ADDR);
  endtask

  task automatic run_program();
    int    stall;
    word_t v0_hold;
    stall = 0;
    @(negedge clk);
    rst_n      = 1'b0;
    clk_enable = 1'b0;   // held low through reset
    reset_model();
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    while (m_active) begin
      if (stall > 0) begin
        clk_enable = 1'b0;
        stall--;
      end else if (xorshift32() % 16 == 0) begin
        clk_enable = 1'b0;
        stall      = int'(xorshift32() % 8);  // stretch of 1 to 8 cycles
      end else begin
        clk_enable = 1'b1;
      end
      #(CLK_PERIOD / 4);  // mid low phase where outputs are settled
      check_pc(m_pc);
      check_active(m_active);
      check_v0(m_regs[2]);
      if (clk_enable) begin
        model_step();
      end else begin
        check_write(1'b0);
        check_read(1'b0);
      end
      @(negedge clk);
    end
    v0_hold = m_regs[2];
    repeat (10) begin     // nothing may move once halted
      clk_enable = (xorshift32() % 2 == 0);
      #(CLK_PERIOD / 4);
      check_pc(`MIPS_HALT_ADDR);
      check_active(1'b0);
      check_v0(v0_hold);
      check_write(1'b0);
      check_read(1'b0);
      @(negedge clk);
    end
  endtask

  initial begin
    rst_n      = 1'b0;
    clk_enable = 1'b0;
    for (prog = 0; prog < NUM_PROGS; prog++) begin
      gen_program();
      run_program();
    end
    $display("Regression passed");
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired: CPU did not halt");
    stop_on_failure();
  end

endmodule

//--- src/mips_cpu_harvard.sv
`timescale 1ns/1ps

module mips_cpu_harvard import mips_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  output logic  active,
  output word_t register_v0,

  input  logic  clk_enable,   // only stall source

  output word_t instr_address,   // current pc
  input  word_t instr_readdata,  // comb fetch from instr_address

  output word_t data_address,    // alu result
  output logic  data_write,
  output logic  data_read,
  output word_t data_writedata,  // rt
  input  word_t data_readdata
);

  instr_t instr;
  ctrl_t  ctrl;
  logic   zero, pc_branch;

  assign instr = instr_readdata;  // same word, decoded by format

  controller control (
    .instr(instr), .zero(zero),
    .ctrl(ctrl), .pc_branch(pc_branch)
  );

  datapath datap (
    .clk(clk), .rst_n(rst_n), .clk_enable(clk_enable),
    .instr(instr), .ctrl(ctrl), .pc_branch(pc_branch),
    .data_readdata(data_readdata),
    .zero(zero), .active(active),
    .data_write(data_write), .data_read(data_read),
    .instr_address(instr_address), .data_address(data_address),
    .data_writedata(data_writedata), .register_v0(register_v0)
  );

endmodule

//--- src/datapath.sv
`timescale 1ns/1ps
`include "mips_cfg.svh"

module datapath import mips_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   clk_enable,
  input  instr_t instr,
  input  ctrl_t  ctrl,
  input  logic   pc_branch,
  input  word_t  data_readdata,
  output logic   zero,
  output logic   active,
  output logic   data_write,
  output logic   data_read,
  output word_t  instr_address,
  output word_t  data_address,
  output word_t  data_writedata,
  output word_t  register_v0
);

  word_t      pc, pc_plus4, pc_next;
  word_t      rs_val, rt_val;
  word_t      imm_ext, br_off;
  word_t      alu_b, alu_y, wb_data;
  logic [4:0] wa;
  logic [4:0] alu_shamt;
  logic       step;   // this edge retires an instruction unless in reset

  assign step = clk_enable & active & rst_n;

  // operand prep
  assign imm_ext   = ctrl.imm_zero_ext ? {16'h0000, instr.i.imm16}
                                       : {{16{instr.i.imm16[15]}}, instr.i.imm16};
  assign br_off    = {{14{instr.i.imm16[15]}}, instr.i.imm16, 2'b00};  // always signed
  assign alu_b     = ctrl.alu_src_imm ? imm_ext : rt_val;
  assign alu_shamt = ctrl.shift_shamt ? instr.r.shamt : 5'd0;

  always_comb begin
    case (ctrl.reg_dst)
      DST_RD:  wa = instr.r.rd;
      DST_R31: wa = 5'd31;
      default: wa = instr.i.rt;
    endcase
    case (ctrl.wb_sel)
      WB_MEM:  wb_data = data_readdata;  // comb load in the same cycle
      WB_LINK: wb_data = pc_plus4;       // no delay slot, so link is pc+4
      default: wb_data = alu_y;
    endcase
  end

  reg_file regs_i (
    .clk(clk), .rst_n(rst_n),
    .we(ctrl.reg_write & step),
    .ra1(instr.r.rs), .ra2(instr.r.rt), .wa(wa),
    .wd(wb_data),
    .rd1(rs_val), .rd2(rt_val), .v0(register_v0)
  );

  alu alu_i (
    .op(ctrl.alu_op), .a(rs_val), .b(alu_b), .shamt(alu_shamt),
    .result(alu_y), .zero(zero)
  );

  // next pc priority is jr, then j/jal, then branch
  assign pc_plus4 = pc + 32'd4;
  always_comb begin
    if (ctrl.jump_reg)  pc_next = rs_val;
    else if (ctrl.jump) pc_next = {pc_plus4[31:28], instr.j.target26, 2'b00};
    else if (pc_branch) pc_next = pc_plus4 + br_off;
    else                pc_next = pc_plus4;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc     <= `MIPS_RESET_VECTOR;
      active <= 1'b1;
    end else if (step) begin
      pc     <= pc_next;
      active <= (pc_next != `MIPS_HALT_ADDR);  // falls on the jump to halt
    end
  end

  assign instr_address  = pc;
  assign data_address   = alu_y;
  assign data_writedata = rt_val;
  assign data_write     = ctrl.mem_write & step;  // low while stalled, halted or in reset
  assign data_read      = ctrl.mem_read & step;

endmodule

//--- src/reg_file.sv
`timescale 1ns/1ps
`include "mips_cfg.svh"

module reg_file import mips_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       we,
  input  logic [4:0] ra1,
  input  logic [4:0] ra2,
  input  logic [4:0] wa,
  input  word_t      wd,
  output word_t      rd1,
  output word_t      rd2,
  output word_t      v0
);

  word_t regs [`MIPS_NUM_REGS];

  // write at the edge, $0 never written so it reads back zero
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (wa != 5'd0)) begin
      regs[wa] <= wd;
    end
  end

  // async read, same-cycle operands
  assign rd1 = regs[ra1];
  assign rd2 = regs[ra2];

  assign v0 = regs[2];  // $v0 tap for the top port

endmodule

//--- src/alu.sv
`timescale 1ns/1ps

module alu import mips_pkg::*; (
  input  alu_op_e    op,
  input  word_t      a,        // rs
  input  word_t      b,        // rt or extended imm
  input  logic [4:0] shamt,
  output word_t      result,
  output logic       zero
);

  always_comb begin
    case (op)
      ALU_ADD:  result = a + b;   // addu/addiu/lw/sw, no overflow trap
      ALU_SUB:  result = a - b;
      ALU_AND:  result = a & b;
      ALU_OR:   result = a | b;
      ALU_XOR:  result = a ^ b;
      ALU_SLT:  result = {31'b0, $signed(a) < $signed(b)};
      ALU_SLTU: result = {31'b0, a < b};
      ALU_SLL:  result = b << shamt;   // shifts act on rt
      ALU_SRL:  result = b >> shamt;   // logical, zero fill
      ALU_LUI:  result = {b[15:0], 16'h0000};
      default:  result = a + b;
    endcase
  end

  // feeds controller for beq/bne
  assign zero = (result == '0);

endmodule

//--- src/controller.sv
`timescale 1ns/1ps

module controller import mips_pkg::*; (
  input  instr_t instr,
  input  logic   zero,       // from datapath alu, rs - rt on branches
  output ctrl_t  ctrl,
  output logic   pc_branch
);

  // main decoder, purely combinational
  always_comb begin
    ctrl        = '0;       // unknown op -> nop, no writes
    ctrl.alu_op = ALU_ADD;
    ctrl.reg_dst = DST_RT;
    ctrl.wb_sel = WB_ALU;
    case (instr.r.op)
      OP_RTYPE: begin
        ctrl.reg_write = 1'b1;
        ctrl.reg_dst   = DST_RD;
        case (instr.r.funct)
          FN_ADDU: ctrl.alu_op = ALU_ADD;
          FN_SUBU: ctrl.alu_op = ALU_SUB;
          FN_AND:  ctrl.alu_op = ALU_AND;
          FN_OR:   ctrl.alu_op = ALU_OR;
          FN_XOR:  ctrl.alu_op = ALU_XOR;
          FN_SLT:  ctrl.alu_op = ALU_SLT;
          FN_SLTU: ctrl.alu_op = ALU_SLTU;
          FN_SLL: begin
            ctrl.alu_op      = ALU_SLL;
            ctrl.shift_shamt = 1'b1;
          end
          FN_SRL: begin
            ctrl.alu_op      = ALU_SRL;
            ctrl.shift_shamt = 1'b1;
          end
          FN_JR: begin
            ctrl.reg_write = 1'b0;   // jr writes nothing
            ctrl.jump_reg  = 1'b1;
          end
          default: ctrl.reg_write = 1'b0;  // unsupported funct
        endcase
      end
      OP_ADDIU, OP_SLTI: begin
        ctrl.reg_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;   // sign-extended imm
        ctrl.alu_op      = (instr.i.op == OP_SLTI) ? ALU_SLT : ALU_ADD;
      end
      OP_ANDI, OP_ORI, OP_XORI: begin
        ctrl.reg_write    = 1'b1;
        ctrl.alu_src_imm  = 1'b1;
        ctrl.imm_zero_ext = 1'b1;
        ctrl.alu_op       = (instr.i.op == OP_ANDI) ? ALU_AND :
                            (instr.i.op == OP_ORI)  ? ALU_OR  : ALU_XOR;
      end
      OP_LUI: begin
        ctrl.reg_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.alu_op      = ALU_LUI;
      end
      OP_LW: begin
        ctrl.reg_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;   // base + offset
        ctrl.mem_read    = 1'b1;
        ctrl.wb_sel      = WB_MEM;
      end
      OP_SW: begin
        ctrl.alu_src_imm = 1'b1;
        ctrl.mem_write   = 1'b1;
      end
      OP_BEQ: begin
        ctrl.branch_eq = 1'b1;
        ctrl.alu_op    = ALU_SUB;  // zero when rs == rt
      end
      OP_BNE: begin
        ctrl.branch_ne = 1'b1;
        ctrl.alu_op    = ALU_SUB;
      end
      OP_J:   ctrl.jump = 1'b1;
      OP_JAL: begin
        ctrl.jump      = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.reg_dst   = DST_R31;  // link into $ra
        ctrl.wb_sel    = WB_LINK;
      end
      default: ;
    endcase
  end

  // branch resolved here, datapath only sees the decision
  assign pc_branch = (ctrl.branch_eq & zero) | (ctrl.branch_ne & ~zero);

endmodule

//--- src/mips_pkg.sv
package mips_pkg;

  typedef logic [31:0] word_t;

  // primary opcodes, instr[31:26]
  localparam logic [5:0] OP_RTYPE = 6'h00, OP_J    = 6'h02, OP_JAL  = 6'h03;
  localparam logic [5:0] OP_BEQ   = 6'h04, OP_BNE  = 6'h05, OP_ADDIU = 6'h09;
  localparam logic [5:0] OP_SLTI  = 6'h0A, OP_ANDI = 6'h0C, OP_ORI  = 6'h0D;
  localparam logic [5:0] OP_XORI  = 6'h0E, OP_LUI  = 6'h0F;
  localparam logic [5:0] OP_LW    = 6'h23, OP_SW   = 6'h2B;

  // funct codes under OP_RTYPE
  localparam logic [5:0] FN_SLL  = 6'h00, FN_SRL  = 6'h02, FN_JR  = 6'h08;
  localparam logic [5:0] FN_ADDU = 6'h21, FN_SUBU = 6'h23, FN_AND = 6'h24;
  localparam logic [5:0] FN_OR   = 6'h25, FN_XOR  = 6'h26;
  localparam logic [5:0] FN_SLT  = 6'h2A, FN_SLTU = 6'h2B;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_LUI
  } alu_op_e;

  typedef enum logic [1:0] {DST_RT, DST_RD, DST_R31} reg_dst_e;  // write-back target
  typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_LINK} wb_sel_e;   // write-back source

  // three views of the same fetched word
  typedef struct packed {
    logic [5:0] op;
    logic [4:0] rs, rt, rd, shamt;
    logic [5:0] funct;
  } r_fmt_t;
  typedef struct packed {logic [5:0] op; logic [4:0] rs, rt; logic [15:0] imm16;} i_fmt_t;
  typedef struct packed {logic [5:0] op; logic [25:0] target26;} j_fmt_t;

  typedef union packed {r_fmt_t r; i_fmt_t i; j_fmt_t j;} instr_t;

  typedef struct packed {
    logic     reg_write;
    reg_dst_e reg_dst;
    logic     alu_src_imm;   // b operand from immediate
    logic     imm_zero_ext;  // logical imm ops
    logic     shift_shamt;   // sll/srl use instr shamt
    logic     mem_read, mem_write;
    wb_sel_e  wb_sel;
    logic     branch_eq, branch_ne;
    logic     jump, jump_reg;
    alu_op_e  alu_op;
  } ctrl_t;

endpackage

//--- src/mips_cfg.svh
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// boot ROM base, PC value once reset lets go
`define MIPS_RESET_VECTOR 32'hBFC00000

// jumping here ends the program and drops active
`define MIPS_HALT_ADDR 32'h00000000

// architectural GPR count, $0 included
`define MIPS_NUM_REGS 32

`endif
